/* bus_pkg.sv */
// Access description shared by all units: bus widths, funct3 load/store codes, host commands
package bus_pkg;

    localparam int ADDR_W = 32;
    localparam int DATA_W = 32;
    localparam int LINE_W = 128;

    // RISC-V funct3, bit 2 marks unsigned, bits 1..0 the size
    localparam logic [2:0] F3_LB  = 3'b000;
    localparam logic [2:0] F3_LH  = 3'b001;
    localparam logic [2:0] F3_LW  = 3'b010;
    localparam logic [2:0] F3_LBU = 3'b100;
    localparam logic [2:0] F3_LHU = 3'b101;
    localparam logic [2:0] F3_SW  = 3'b010;

    // Upper half of the host command word
    localparam logic [15:0] CMD_PRINT_CHAR = 16'h0101;
    localparam logic [15:0] CMD_POWER_OFF  = 16'h0200;

endpackage

/* mem_map_pkg.sv */
// Physical address map of the SoC data side; imported by the router, the top and the testbench
package mem_map_pkg;

    // Target chosen for the read return path
    typedef enum logic [2:0] {
        DEV_DRAM  = 3'd0,
        DEV_PLIC  = 3'd1,
        DEV_CLINT = 3'd2,
        DEV_FB    = 3'd3,
        DEV_NONE  = 3'd4
    } dev_sel_t;

    // Codes of address bits 31..28
    localparam logic [3:0] DEV_CODE_DRAM_LO = 4'd0;
    localparam logic [3:0] DEV_CODE_DRAM_HI = 4'd8;
    localparam logic [3:0] DEV_CODE_VIRTIO  = 4'd4;
    localparam logic [3:0] DEV_CODE_PLIC    = 4'd5;
    localparam logic [3:0] DEV_CODE_CLINT   = 4'd6;

    // Slot of the framebuffer in address bits 27..24 of the device region
    localparam logic [3:0] VIRT_FB = 4'd5;

    // Host command register sits in the otherwise unused slot 0
    localparam logic [31:0] TOHOST_ADDR = 32'h4000_0000;

    // DRAM sees only bits 26..0
    localparam logic [31:0] DRAM_OFFSET_MASK = 32'h07FF_FFFF;

endpackage

/* device_router.sv */
// Decodes a processor data access into device strobes and returns read data one cycle later
`timescale 1ns/1ps

module device_router
    import bus_pkg::*;
    import mem_map_pkg::*;
(
    input  logic              CLK,
    input  logic              arst_n,
    input  logic              init_done,
    input  logic [ADDR_W-1:0] data_addr,
    input  logic              data_we,
    input  logic              data_re,
    input  logic [DATA_W-1:0] plic_rdata,
    input  logic [DATA_W-1:0] clint_rdata,
    input  logic [DATA_W-1:0] fb_rdata,
    input  logic [DATA_W-1:0] dram_word,
    output logic              cpu_dram_we,
    output logic              cpu_dram_re,
    output logic              plic_we,
    output logic              plic_re,
    output logic              clint_we,
    output logic              fb_we,
    output logic              tohost_we,
    output logic [DATA_W-1:0] data_rdata
);

    logic [3:0] dev;
    logic [3:0] virt;
    logic       is_dram;
    logic       is_plic;
    logic       is_clint;
    logic       is_fb;
    logic       is_tohost;
    dev_sel_t   sel_d;
    dev_sel_t   sel_q;

    assign dev  = data_addr[31:28];
    assign virt = data_addr[27:24];

    // Low and high DRAM windows alias onto the same memory
    assign is_dram   = (dev == DEV_CODE_DRAM_LO) || (dev == DEV_CODE_DRAM_HI);
    assign is_plic   = (dev == DEV_CODE_PLIC);
    assign is_clint  = (dev == DEV_CODE_CLINT);
    assign is_fb     = (dev == DEV_CODE_VIRTIO) && (virt == VIRT_FB);
    assign is_tohost = (data_addr == TOHOST_ADDR);

    assign cpu_dram_we = init_done && data_we && is_dram;
    assign cpu_dram_re = init_done && data_re && is_dram;
    assign plic_we     = init_done && data_we && is_plic;
    assign plic_re     = init_done && data_re && is_plic;
    assign clint_we    = init_done && data_we && is_clint;
    assign fb_we       = init_done && data_we && is_fb;
    assign tohost_we   = init_done && data_we && is_tohost;

    always_comb begin
        if (is_dram) begin
            sel_d = DEV_DRAM;
        end else if (is_plic) begin
            sel_d = DEV_PLIC;
        end else if (is_clint) begin
            sel_d = DEV_CLINT;
        end else if (is_fb) begin
            sel_d = DEV_FB;
        end else begin
            sel_d = DEV_NONE;
        end
    end

    // Select follows the most recent read
    always_ff @(posedge CLK or negedge arst_n) begin
        if (!arst_n) begin
            sel_q <= DEV_NONE;
        end else if (data_re) begin
            sel_q <= sel_d;
        end
    end

    always_comb begin
        case (sel_q)
            DEV_DRAM:  data_rdata = dram_word;
            DEV_PLIC:  data_rdata = plic_rdata;
            DEV_CLINT: data_rdata = clint_rdata;
            DEV_FB:    data_rdata = fb_rdata;
            default:   data_rdata = '0;
        endcase
    end

endmodule

/* load_align.sv */
// Picks the load word out of the 128-bit DRAM line and applies byte/halfword extension
`timescale 1ns/1ps

module load_align
    import bus_pkg::*;
(
    input  logic              CLK,
    input  logic              arst_n,
    input  logic              capture,
    input  logic [3:0]        byte_offset,
    input  logic [2:0]        ctrl,
    input  logic [LINE_W-1:0] dram_rdata128,
    output logic [DATA_W-1:0] dram_word
);

    logic [3:0]        offset_q;
    logic [2:0]        ctrl_q;
    logic [LINE_W-1:0] shifted;
    logic [DATA_W-1:0] raw;
    logic              sign_en;

    // Offset and width of the last DRAM access
    always_ff @(posedge CLK or negedge arst_n) begin
        if (!arst_n) begin
            offset_q <= '0;
            ctrl_q   <= '0;
        end else if (capture) begin
            offset_q <= byte_offset;
            ctrl_q   <= ctrl;
        end
    end

    assign shifted = dram_rdata128 >> {offset_q, 3'b000};
    assign raw     = shifted[DATA_W-1:0];
    assign sign_en = !ctrl_q[2];

    always_comb begin
        case (ctrl_q[1:0])
            2'b00:   dram_word = {{24{raw[7] & sign_en}}, raw[7:0]};
            2'b01:   dram_word = {{16{raw[15] & sign_en}}, raw[15:0]};
            default: dram_word = raw;
        endcase
    end

endmodule

/* host_cmd.sv */
// Host command register; turns print commands into a UART byte strobe and latches power-off
`timescale 1ns/1ps

module host_cmd
    import bus_pkg::*;
(
    input  logic              CLK,
    input  logic              arst_n,
    input  logic              tohost_we,
    input  logic [DATA_W-1:0] wdata,
    output logic              uart_we,
    output logic [7:0]        uart_data,
    output logic              finish
);

    logic [DATA_W-1:0] tohost_q;
    logic              is_print;
    logic              is_power_off;

    assign is_print     = (tohost_q[31:16] == CMD_PRINT_CHAR);
    assign is_power_off = (tohost_q[31:16] == CMD_POWER_OFF);

    always_ff @(posedge CLK or negedge arst_n) begin
        if (!arst_n) begin
            tohost_q <= '0;
            uart_we  <= 1'b0;
            finish   <= 1'b0;
        end else begin
            uart_we <= is_print;
            // A print is consumed once emitted
            if (tohost_we) begin
                tohost_q <= wdata;
            end else if (is_print) begin
                tohost_q <= '0;
            end
            if (is_power_off) begin
                finish <= 1'b1;
            end
        end
    end

    // Character byte, only meaningful with uart_we
    always_ff @(posedge CLK) begin
        if (is_print) begin
            uart_data <= tohost_q[7:0];
        end
    end

endmodule

/* boot_loader.sv */
// Boot sequencer; writes the boot image then the device tree into DRAM and sums every word
`timescale 1ns/1ps

module boot_loader
    import bus_pkg::*;
#(
    parameter int              BBL_WORDS = 1024,
    parameter int              DTB_WORDS = 256,
    parameter logic [ADDR_W-1:0] DTB_BASE  = 32'h0010_0000
) (
    input  logic              CLK,
    input  logic              arst_n,
    input  logic              loader_we,
    input  logic [DATA_W-1:0] loader_data,
    output logic              load_we,
    output logic [ADDR_W-1:0] load_addr,
    output logic              init_done,
    output logic [DATA_W-1:0] checksum
);

    localparam int BBL_CW = $clog2(BBL_WORDS + 1);
    localparam int DTB_CW = $clog2(DTB_WORDS + 1);

    typedef enum logic [1:0] {
        ST_BBL  = 2'd0,
        ST_DTB  = 2'd1,
        ST_DONE = 2'd2
    } load_state_t;

    load_state_t       state;
    logic [BBL_CW-1:0] bbl_cnt;
    logic [DTB_CW-1:0] dtb_cnt;

    assign load_we   = loader_we && (state != ST_DONE);
    assign init_done = (state == ST_DONE);

    always_ff @(posedge CLK or negedge arst_n) begin
        if (!arst_n) begin
            state     <= ST_BBL;
            bbl_cnt   <= '0;
            dtb_cnt   <= '0;
            load_addr <= '0;
            checksum  <= '0;
        end else if (load_we) begin
            checksum <= checksum + loader_data;
            if (state == ST_BBL) begin
                // Last image word moves the pointer to the device tree
                if (bbl_cnt == BBL_CW'(BBL_WORDS - 1)) begin
                    state     <= ST_DTB;
                    load_addr <= DTB_BASE;
                end else begin
                    bbl_cnt   <= bbl_cnt + 1'b1;
                    load_addr <= load_addr + 32'd4;
                end
            end else begin
                if (dtb_cnt == DTB_CW'(DTB_WORDS - 1)) begin
                    state <= ST_DONE;
                end else begin
                    dtb_cnt   <= dtb_cnt + 1'b1;
                    load_addr <= load_addr + 32'd4;
                end
            end
        end
    end

endmodule

/* mem_interconnect.sv */
// Data-side memory interconnect top; arbitrates DRAM between boot loader and processor
`timescale 1ns/1ps

module mem_interconnect
    import bus_pkg::*;
    import mem_map_pkg::*;
#(
    parameter int                BBL_WORDS = 1024,
    parameter int                DTB_WORDS = 256,
    parameter logic [ADDR_W-1:0] DTB_BASE  = 32'h0010_0000
) (
    input  logic              CLK,
    input  logic              arst_n,
    // Processor data port
    input  logic [ADDR_W-1:0] data_addr,
    input  logic [DATA_W-1:0] data_wdata,
    input  logic              data_we,
    input  logic              data_re,
    input  logic [2:0]        data_ctrl,
    output logic [DATA_W-1:0] data_rdata,
    output logic              proc_busy,
    // DRAM
    input  logic              dram_busy,
    output logic              dram_wr_en,
    output logic              dram_rd_en,
    output logic [ADDR_W-1:0] dram_addr,
    output logic [DATA_W-1:0] dram_wdata,
    output logic [2:0]        dram_ctrl,
    input  logic [LINE_W-1:0] dram_rdata128,
    // Devices
    output logic              plic_we,
    output logic              plic_re,
    output logic              clint_we,
    output logic              fb_we,
    output logic [DATA_W-1:0] dev_wdata,
    input  logic [DATA_W-1:0] plic_rdata,
    input  logic [DATA_W-1:0] clint_rdata,
    input  logic [DATA_W-1:0] fb_rdata,
    // Loader
    input  logic              loader_we,
    input  logic [DATA_W-1:0] loader_data,
    output logic              init_done,
    output logic [DATA_W-1:0] checksum,
    // Host
    output logic              uart_we,
    output logic [7:0]        uart_data,
    output logic              finish
);

    logic              cpu_dram_we;
    logic              cpu_dram_re;
    logic              tohost_we;
    logic              load_we;
    logic [ADDR_W-1:0] load_addr;
    logic [DATA_W-1:0] dram_word;

    assign proc_busy = !init_done || dram_busy;
    assign dev_wdata = data_wdata;

    // Loader owns DRAM until init_done
    assign dram_wr_en = load_we || (cpu_dram_we && !dram_busy);
    assign dram_rd_en = cpu_dram_re && !dram_busy;
    assign dram_addr  = init_done ? (data_addr & DRAM_OFFSET_MASK) : load_addr;
    assign dram_wdata = init_done ? data_wdata : loader_data;
    assign dram_ctrl  = init_done ? data_ctrl : F3_SW;

    device_router u_router (
        .CLK         (CLK),
        .arst_n      (arst_n),
        .init_done   (init_done),
        .data_addr   (data_addr),
        .data_we     (data_we),
        .data_re     (data_re),
        .plic_rdata  (plic_rdata),
        .clint_rdata (clint_rdata),
        .fb_rdata    (fb_rdata),
        .dram_word   (dram_word),
        .cpu_dram_we (cpu_dram_we),
        .cpu_dram_re (cpu_dram_re),
        .plic_we     (plic_we),
        .plic_re     (plic_re),
        .clint_we    (clint_we),
        .fb_we       (fb_we),
        .tohost_we   (tohost_we),
        .data_rdata  (data_rdata)
    );

    load_align u_align (
        .CLK           (CLK),
        .arst_n        (arst_n),
        .capture       (dram_wr_en || dram_rd_en),
        .byte_offset   (dram_addr[3:0]),
        .ctrl          (dram_ctrl),
        .dram_rdata128 (dram_rdata128),
        .dram_word     (dram_word)
    );

    host_cmd u_host (
        .CLK       (CLK),
        .arst_n    (arst_n),
        .tohost_we (tohost_we),
        .wdata     (data_wdata),
        .uart_we   (uart_we),
        .uart_data (uart_data),
        .finish    (finish)
    );

    boot_loader #(
        .BBL_WORDS (BBL_WORDS),
        .DTB_WORDS (DTB_WORDS),
        .DTB_BASE  (DTB_BASE)
    ) u_loader (
        .CLK         (CLK),
        .arst_n      (arst_n),
        .loader_we   (loader_we),
        .loader_data (loader_data),
        .load_we     (load_we),
        .load_addr   (load_addr),
        .init_done   (init_done),
        .checksum    (checksum)
    );

endmodule

/* tb_mem_interconnect.sv */
// Self-checking testbench for mem_interconnect; compiled from build.f and run by run.sh
`timescale 1ns/1ps

module tb_mem_interconnect
    import bus_pkg::*;
    import mem_map_pkg::*;
();

    localparam int              BBL_WORDS      = 8;
    localparam int              DTB_WORDS      = 4;
    localparam logic [ADDR_W-1:0] DTB_BASE     = 32'h100;
    // Whole run takes a few hundred cycles
    localparam int              TIMEOUT_CYCLES = 2000;

    logic              CLK;
    logic              arst_n;
    logic [ADDR_W-1:0] data_addr;
    logic [DATA_W-1:0] data_wdata;
    logic              data_we;
    logic              data_re;
    logic [2:0]        data_ctrl;
    logic [DATA_W-1:0] data_rdata;
    logic              proc_busy;
    logic              dram_busy;
    logic              dram_wr_en;
    logic              dram_rd_en;
    logic [ADDR_W-1:0] dram_addr;
    logic [DATA_W-1:0] dram_wdata;
    logic [2:0]        dram_ctrl;
    logic [LINE_W-1:0] dram_rdata128;
    logic              plic_we;
    logic              plic_re;
    logic              clint_we;
    logic              fb_we;
    logic [DATA_W-1:0] dev_wdata;
    logic [DATA_W-1:0] plic_rdata;
    logic [DATA_W-1:0] clint_rdata;
    logic [DATA_W-1:0] fb_rdata;
    logic              loader_we;
    logic [DATA_W-1:0] loader_data;
    logic              init_done;
    logic [DATA_W-1:0] checksum;
    logic              uart_we;
    logic [7:0]        uart_data;
    logic              finish;

    logic [31:0] rand_state;
    int          cycle_count = 0;
    logic [2:0]  load_codes [5] = '{F3_LB, F3_LH, F3_LW, F3_LBU, F3_LHU};

    mem_interconnect #(
        .BBL_WORDS (BBL_WORDS),
        .DTB_WORDS (DTB_WORDS),
        .DTB_BASE  (DTB_BASE)
    ) DUT (.*);

    always #5 CLK = ~CLK;

    task automatic fail_run();
        $display("FAIL: see errors above");
        $fatal(1, "simulation stopped at first error");
    endtask

    function automatic logic [31:0] next_rand();
        rand_state = rand_state * 32'd1664525 + 32'd1013904223;
        return rand_state;
    endfunction

    task automatic compare_value(input string name, input logic [127:0] expected,
                                 input logic [127:0] actual);
        assert (actual === expected) else begin
            $display("MISMATCH at %0t: %s expected %0h, got %0h",
                     $time, name, expected, actual);
            fail_run();
        end
    endtask

    // Order is plic_we, plic_re, clint_we, fb_we, dram_wr_en, dram_rd_en
    task automatic expect_strobes(input logic [5:0] expected);
        compare_value("strobes", expected,
                      {plic_we, plic_re, clint_we, fb_we, dram_wr_en, dram_rd_en});
    endtask

    task automatic next_cycle();
        @(posedge CLK);
        #1;
    endtask

    task automatic idle_bus();
        data_we   = 1'b0;
        data_re   = 1'b0;
        loader_we = 1'b0;
    endtask

    // Aligned offsets keep every part-select inside the line
    function automatic logic [31:0] load_word_model(input logic [127:0] line,
                                                    input logic [3:0] off,
                                                    input logic [2:0] f3);
        int          lsb;
        logic [31:0] result;
        lsb = int'(off) * 8;
        case (f3)
            F3_LB:   result = {{24{line[lsb+7]}}, line[lsb +: 8]};
            F3_LBU:  result = {24'd0, line[lsb +: 8]};
            F3_LH:   result = {{16{line[lsb+15]}}, line[lsb +: 16]};
            F3_LHU:  result = {16'd0, line[lsb +: 16]};
            default: result = line[lsb +: 32];
        endcase
        return result;
    endfunction

    // One device request, then the read return one cycle later
    task automatic device_access(input logic [31:0] addr, input logic write,
                                 input logic [5:0] strobes, input logic [31:0] rdata_exp);
        next_cycle();
        data_addr  = addr;
        data_wdata = next_rand();
        data_we    = write;
        data_re    = !write;
        #1;
        expect_strobes(strobes);
        if (write) begin
            compare_value("dev_wdata", data_wdata, dev_wdata);
        end
        next_cycle();
        idle_bus();
        #1;
        if (!write) begin
            compare_value("data_rdata", rdata_exp, data_rdata);
        end
    endtask

    // DRAM never gets both enables in the same cycle
    assert property (@(posedge CLK) disable iff (!arst_n)
        !(dram_wr_en && dram_rd_en))
    else begin
        $display("ERROR: DRAM write and read enables were raised in the same cycle");
        fail_run();
    end

    always @(posedge CLK) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("ERROR: timeout, tests did not finish within %0d cycles",
                     TIMEOUT_CYCLES);
            fail_run();
        end
    end

    initial begin
        logic [31:0]  word;
        logic [31:0]  r;
        logic [31:0]  a;
        logic [31:0]  addr;
        logic [31:0]  exp_addr;
        logic [31:0]  exp_sum;
        logic [3:0]   off;
        logic [2:0]   f3;
        logic [127:0] line;

        rand_state    = 32'd53501;
        CLK           = 1'b0;
        arst_n        = 1'b0;
        data_addr     = '0;
        data_wdata    = '0;
        data_we       = 1'b0;
        data_re       = 1'b0;
        data_ctrl     = '0;
        dram_busy     = 1'b0;
        dram_rdata128 = '0;
        plic_rdata    = '0;
        clint_rdata   = '0;
        fb_rdata      = '0;
        loader_we     = 1'b0;
        loader_data   = '0;
        exp_sum       = '0;

        repeat (2) @(posedge CLK);
        #1;
        arst_n = 1'b1;
        compare_value("proc_busy", 1, proc_busy);
        compare_value("init_done", 0, init_done);
        compare_value("checksum", 0, checksum);
        compare_value("finish", 0, finish);

        // Boot image then device tree
        for (int i = 0; i < BBL_WORDS + DTB_WORDS; i++) begin
            next_cycle();
            word     = next_rand();
            exp_sum  = exp_sum + word;
            exp_addr = (i < BBL_WORDS) ? 32'(i * 4) : DTB_BASE + 32'((i - BBL_WORDS) * 4);
            loader_we   = 1'b1;
            loader_data = word;
            #1;
            compare_value("proc_busy", 1, proc_busy);
            compare_value("init_done", 0, init_done);
            compare_value("dram_wr_en", 1, dram_wr_en);
            compare_value("dram_addr", exp_addr, dram_addr);
            compare_value("dram_wdata", word, dram_wdata);
            compare_value("dram_ctrl", F3_SW, dram_ctrl);
        end
        next_cycle();
        idle_bus();
        #1;
        compare_value("init_done", 1, init_done);
        compare_value("proc_busy", 0, proc_busy);
        compare_value("checksum", exp_sum, checksum);

        // A late loader word must be dropped, also next to a DRAM read
        next_cycle();
        loader_we   = 1'b1;
        loader_data = next_rand();
        data_addr   = '0;
        data_re     = 1'b1;
        #1;
        expect_strobes(6'b000001);
        next_cycle();
        idle_bus();
        #1;
        compare_value("checksum", exp_sum, checksum);

        for (int i = 0; i < 50; i++) begin
            next_cycle();
            r    = next_rand();
            addr = {r[31] ? DEV_CODE_DRAM_HI : DEV_CODE_DRAM_LO, r[27:0]};
            data_addr  = addr;
            data_wdata = next_rand();
            data_ctrl  = r[30:28];
            data_we    = 1'b1;
            #1;
            expect_strobes(6'b000010);
            compare_value("dram_addr", addr & DRAM_OFFSET_MASK, dram_addr);
            compare_value("dram_wdata", data_wdata, dram_wdata);
            compare_value("dram_ctrl", data_ctrl, dram_ctrl);
            next_cycle();
            idle_bus();
        end

        for (int i = 0; i < 100; i++) begin
            next_cycle();
            r  = next_rand();
            a  = next_rand();
            f3 = load_codes[int'(r % 5)];
            case (f3[1:0])
                2'b00:   off = r[7:4];
                2'b01:   off = {r[7:5], 1'b0};
                default: off = {r[7:6], 2'b00};
            endcase
            line          = {next_rand(), next_rand(), next_rand(), next_rand()};
            dram_rdata128 = line;
            data_addr     = {a[31] ? DEV_CODE_DRAM_HI : DEV_CODE_DRAM_LO, a[27:4], off};
            data_ctrl     = f3;
            data_re       = 1'b1;
            #1;
            expect_strobes(6'b000001);
            next_cycle();
            idle_bus();
            #1;
            compare_value("data_rdata", load_word_model(line, off, f3), data_rdata);
        end

        plic_rdata  = next_rand();
        clint_rdata = next_rand();
        fb_rdata    = next_rand();
        r = next_rand();
        device_access({DEV_CODE_PLIC, r[27:0]}, 1'b1, 6'b100000, '0);
        device_access({DEV_CODE_PLIC, r[27:0]}, 1'b0, 6'b010000, plic_rdata);
        device_access({DEV_CODE_CLINT, r[27:0]}, 1'b1, 6'b001000, '0);
        device_access({DEV_CODE_CLINT, r[27:0]}, 1'b0, 6'b000000, clint_rdata);
        device_access({DEV_CODE_VIRTIO, VIRT_FB, r[23:0]}, 1'b1, 6'b000100, '0);
        device_access({DEV_CODE_VIRTIO, VIRT_FB, r[23:0]}, 1'b0, 6'b000000, fb_rdata);
        // Empty virtual slot reads as zero
        device_access({DEV_CODE_VIRTIO, 4'd2, r[23:0]}, 1'b0, 6'b000000, '0);

        // Print command, strobe expected after the second edge
        next_cycle();
        r = next_rand();
        data_addr  = TOHOST_ADDR;
        data_wdata = {CMD_PRINT_CHAR, 8'h00, r[7:0]};
        data_we    = 1'b1;
        #1;
        expect_strobes(6'b000000);
        compare_value("uart_we", 0, uart_we);
        next_cycle();
        idle_bus();
        #1;
        compare_value("uart_we", 0, uart_we);
        next_cycle();
        compare_value("uart_we", 1, uart_we);
        compare_value("uart_data", r[7:0], uart_data);
        next_cycle();
        compare_value("uart_we", 0, uart_we);

        next_cycle();
        data_addr  = TOHOST_ADDR;
        data_wdata = {CMD_POWER_OFF, r[31:16]};
        data_we    = 1'b1;
        #1;
        compare_value("finish", 0, finish);
        next_cycle();
        idle_bus();
        #1;
        compare_value("finish", 0, finish);
        next_cycle();
        compare_value("finish", 1, finish);
        repeat (3) next_cycle();
        compare_value("finish", 1, finish);
        compare_value("uart_we", 0, uart_we);

        $display("PASS: all tests");
        $finish;
    end

endmodule

/* build.f */
bus_pkg.sv
mem_map_pkg.sv
device_router.sv
load_align.sv
host_cmd.sv
boot_loader.sv
mem_interconnect.sv
tb_mem_interconnect.sv

/* run.sh */
#!/bin/sh
# Build and run the interconnect testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_mem_interconnect -f build.f -o sim_tb
if [ $? -ne 0 ]; then
    echo "Verilator compile failed"
    exit 1
fi

out=$(./obj_dir/sim_tb 2>&1)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -q "^PASS: all tests$"; then
    exit 0
fi
echo "Pass message not found in simulation output"
exit 1
